// File: Makefile
VERILATOR ?= verilator
TOP       ?= pcs_block_sync_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/pcs_block_sync_props.sv
`timescale 1ns/1ns
`default_nettype none

module pcs_block_sync_props
#(
	parameter int GOOD_TO_LOCK = 64
)
(
	input wire                                                 i_clock,
	input wire                                                 i_reset,
	input wire                                                 i_signal_ok,
	input wire [pcs_sync_pkg::NB_HEADER-1:0]                   i_header,
	input wire                                                 i_header_valid,
	input wire                                                 i_block_lock,
	input wire                                                 i_slip,
	input wire [$bits(pcs_sync_pkg::lock_state_t)-1:0]         i_state
);

	localparam int NB_RUN = $clog2(GOOD_TO_LOCK + 1);

	logic [NB_RUN-1:0] good_run;    // consecutive valid headers, saturating
	logic              header_ok;

	assign header_ok = (i_header == pcs_sync_pkg::SH_DATA) || (i_header == pcs_sync_pkg::SH_CTRL);

	always_ff @(posedge i_clock)
	begin
		if (i_reset || !i_signal_ok)
			good_run <= '0;
		else if (i_header_valid && !header_ok)
			good_run <= '0;
		else if (i_header_valid && (good_run != NB_RUN'(GOOD_TO_LOCK)))
			good_run <= good_run + NB_RUN'(1);
	end

	assert property (@(posedge i_clock) disable iff (i_reset) i_slip |=> !i_slip)
		else $error("slip strobe high for two cycles");

	assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_block_lock) |-> (good_run == NB_RUN'(GOOD_TO_LOCK)))
		else $error("block lock rose without a full run of valid headers");

	assert property (@(posedge i_clock) disable iff (i_reset) i_header_valid |=> !i_header_valid)
		else $error("block strobe high for two cycles");

	// lock register agrees with the hunting states
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_block_lock |-> ((i_state != pcs_sync_pkg::LOCK_INIT) &&
		                  (i_state != pcs_sync_pkg::TEST_SH) &&
		                  (i_state != pcs_sync_pkg::SLIP)))
		else $error("block lock high in a hunting state");

endmodule

`default_nettype wire

// File: bench/pcs_block_sync_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pcs_block_sync_tb;

	localparam int NB_WORD      = 32;
	localparam int GOOD_TO_LOCK = 64;
	localparam int NB_PAYLOAD   = pcs_sync_pkg::NB_PAYLOAD;
	localparam int NB_HEADER    = pcs_sync_pkg::NB_HEADER;
	localparam int TAP_A        = pcs_sync_pkg::SCR_TAP_A;
	localparam int TAP_B        = pcs_sync_pkg::SCR_TAP_B;
	localparam int HUNT_LIMIT   = 66 * 65 + 200;    // blocks allowed for acquisition
	localparam int NUM_ROWS     = 6;

	// per row: blocks, invalid headers spread through them, signal ok, lock at the end
	int row_blocks  [NUM_ROWS] = '{4600, 1024, 1024, 4600, 200, 4600};
	int row_invalid [NUM_ROWS] = '{0, 64, 128, 0, 0, 0};
	bit row_sig_ok  [NUM_ROWS] = '{1, 1, 1, 1, 0, 1};
	bit row_lock    [NUM_ROWS] = '{1, 1, 0, 1, 0, 1};

	logic                  clock;
	logic                  reset;
	logic [NB_WORD-1:0]    data;
	logic                  data_valid;
	logic                  signal_ok;
	wire  [NB_PAYLOAD-1:0] dut_data;
	wire  [NB_HEADER-1:0]  dut_header;
	wire                   dut_data_valid;
	wire                   dut_lock;

	integer                seed = 32'h568e1e05;
	logic [TAP_B-1:0]      scr_hist = '0;      // bit TAP_B-k was sent k bits ago
	bit                    stream [$];         // serialized bits, oldest first
	logic [NB_PAYLOAD-1:0] exp_payload [$];
	logic [NB_HEADER-1:0]  exp_header [$];
	int                    cycle_count = 0;
	int                    cycle_limit = 200;
	int                    hunt_blocks = 0;
	int                    compared = 0;
	bit                    lock_prev = 1'b0;
	bit                    ok_prev = 1'b1;
	bit                    synced = 1'b0;

	pcs_block_sync
	#(
		.NB_WORD         (NB_WORD),
		.GOOD_TO_LOCK    (GOOD_TO_LOCK),
		.WINDOW_HEADERS  (1024),
		.INVALID_TO_SLIP (65)
	)
	pcs_block_sync_inst
	(
		.i_clock      (clock),
		.i_reset      (reset),
		.i_data       (data),
		.i_data_valid (data_valid),
		.i_signal_ok  (signal_ok),
		.o_data       (dut_data),
		.o_header     (dut_header),
		.o_data_valid (dut_data_valid),
		.o_block_lock (dut_lock)
	);

	bind block_lock_fsm pcs_block_sync_props
	#(
		.GOOD_TO_LOCK (GOOD_TO_LOCK)
	)
	props_inst
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_signal_ok    (i_signal_ok),
		.i_header       (i_header),
		.i_header_valid (i_header_valid),
		.i_block_lock   (o_block_lock),
		.i_slip         (o_slip),
		.i_state        (state)
	);

	always #4 clock = ~clock;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "run stopped at first error");
	endtask

	// scramble one payload and append header plus payload to the bit stream
	task automatic add_block(input bit bad_header);
		logic [31:0]           rnd;
		logic [NB_PAYLOAD-1:0] plain;
		logic [NB_HEADER-1:0]  header;
		logic                  s;
		rnd   = $random(seed);
		plain = {$random(seed), $random(seed)};
		if (bad_header)
			header = rnd[0] ? 2'b11 : 2'b00;
		else
			header = rnd[0] ? pcs_sync_pkg::SH_CTRL : pcs_sync_pkg::SH_DATA;
		exp_payload.push_back(plain);
		exp_header.push_back(header);
		stream.push_back(header[0]);
		stream.push_back(header[1]);
		for (int i = 0; i < NB_PAYLOAD; i++)
		begin
			s        = plain[i] ^ scr_hist[TAP_B-TAP_A] ^ scr_hist[0];
			scr_hist = {s, scr_hist[TAP_B-1:1]};
			stream.push_back(s);
		end
	endtask

	task automatic send_words(input bit sig_ok);
		logic [NB_WORD-1:0] w;
		while (stream.size() >= NB_WORD)
		begin
			for (int j = 0; j < NB_WORD; j++)
				w[j] = stream.pop_front();      // first bit in the lsb
			@(posedge clock);
			#1;
			data       = w;
			data_valid = 1'b1;
			signal_ok  = sig_ok;
		end
	endtask

	task automatic check_payload();
		if (!synced)
		begin
			// locate the first locked block among the sent ones
			while ((exp_payload.size() > 0) && (exp_payload[0] != dut_data))
			begin
				void'(exp_payload.pop_front());
				void'(exp_header.pop_front());
			end
			synced = 1'b1;
		end
		assert (exp_payload.size() > 0)
			else stop_with_error($sformatf("Mismatch at %0t: payload %h never sent", $time, dut_data));
		assert ((dut_data == exp_payload[0]) && (dut_header == exp_header[0]))
			else stop_with_error($sformatf("Mismatch at %0t: got %h/%b, expected %h/%b",
				$time, dut_data, dut_header, exp_payload[0], exp_header[0]));
		void'(exp_payload.pop_front());
		void'(exp_header.pop_front());
		compared++;
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			stop_with_error($sformatf("Timeout: run did not end within %0d cycles", cycle_limit));
	end

	always @(negedge clock)
	begin
		if (!reset)
		begin
			assert (ok_prev || !dut_lock)
				else stop_with_error($sformatf("Mismatch at %0t: lock high after signal loss", $time));
			if (!signal_ok || (lock_prev && !dut_lock))
				hunt_blocks = 0;                // hunting starts over
			else if (dut_data_valid && !lock_prev)
				hunt_blocks++;
			assert (!signal_ok || dut_lock || (hunt_blocks <= HUNT_LIMIT))
				else stop_with_error($sformatf("block lock not acquired within %0d blocks", HUNT_LIMIT));
			assert (!(dut_lock && !lock_prev) || (hunt_blocks >= GOOD_TO_LOCK))
				else stop_with_error($sformatf("Mismatch at %0t: lock after only %0d blocks",
					$time, hunt_blocks));
			if (!dut_lock)
				synced = 1'b0;
			else if (dut_data_valid && lock_prev)
				check_payload();                // block that set lock is skipped
			lock_prev = dut_lock;
			ok_prev   = signal_ok;
		end
	end

	initial
	begin
		int offset;
		int spacing;
		int bad_count;
		bit bad;
		clock      = 1'b0;
		reset      = 1'b1;
		data       = '0;
		data_valid = 1'b0;
		signal_ok  = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			cycle_limit += 3 * row_blocks[r];
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		assert (!dut_data_valid && !dut_lock)
			else stop_with_error("outputs not low after reset");
		offset = int'({$random(seed)} % 32'd66);
		for (int b = 0; b < offset; b++)
			stream.push_back(bit'($random(seed)));
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			bad_count = 0;
			spacing   = (row_invalid[r] > 0) ? row_blocks[r] / row_invalid[r] : 0;
			for (int j = 0; j < row_blocks[r]; j++)
			begin
				bad = (spacing > 0) && (j % spacing == spacing / 2) && (bad_count < row_invalid[r]);
				bad_count += int'(bad);
				add_block(bad);
			end
			send_words(row_sig_ok[r]);
			@(negedge clock);
			assert (dut_lock == row_lock[r])
				else stop_with_error($sformatf("Mismatch at %0t: lock %0b after row %0d, expected %0b",
					$time, dut_lock, r, row_lock[r]));
		end
		@(posedge clock);
		#1;
		data_valid = 1'b0;
		assert (compared > 0)
			else stop_with_error("no payload was compared while locked");
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
verilog/pcs_sync_pkg.sv
verilog/block_aligner.sv
verilog/block_lock_fsm.sv
verilog/descrambler.sv
verilog/pcs_block_sync.sv
bench/pcs_block_sync_props.sv
bench/pcs_block_sync_tb.sv

// File: verilog/block_aligner.sv
`timescale 1ns/1ns
`default_nettype none

module block_aligner
#(
	parameter int NB_WORD = 32
)
(
	input  wire                                i_clock,
	input  wire                                i_reset,
	input  wire [NB_WORD-1:0]                  i_data,
	input  wire                                i_data_valid,
	input  wire                                i_slip,
	output wire [pcs_sync_pkg::NB_BLOCK-1:0]   o_block,
	output wire                                o_block_valid
);

	localparam int NB_BLOCK = pcs_sync_pkg::NB_BLOCK;
	localparam int NB_ACC   = 2 * NB_BLOCK;      // room for 65 leftover bits plus one word
	localparam int NB_FILL  = $clog2(NB_ACC + 1);

	logic [NB_ACC-1:0]   acc;                    // bit 0 is the oldest bit
	logic [NB_FILL-1:0]  fill;
	logic                slip_pend;
	logic [NB_ACC-1:0]   keep_mask;
	logic [NB_ACC-1:0]   word_ext;
	logic [NB_ACC-1:0]   acc_cat;
	logic [NB_FILL-1:0]  fill_cat;
	logic                slip_req;
	logic                slip_take;
	logic [NB_ACC-1:0]   acc_next;
	logic [NB_FILL-1:0]  fill_next;
	logic                block_ready;
	logic [NB_BLOCK-1:0] block_q;
	logic                block_valid_q;

	// only the low fill bits of acc hold data
	assign keep_mask = ~({NB_ACC{1'b1}} << fill);
	assign word_ext  = {{(NB_ACC - NB_WORD){1'b0}}, i_data};

	// append the new word behind the buffered bits
	always_comb
	begin
		acc_cat  = acc & keep_mask;
		fill_cat = fill;
		if (i_data_valid)
		begin
			acc_cat  = acc_cat | (word_ext << fill);
			fill_cat = fill + NB_FILL'(NB_WORD);
		end
	end

	// a slip seen on an empty buffer waits for the next word
	assign slip_req  = i_slip || slip_pend;
	assign slip_take = slip_req && (fill_cat != '0);

	assign acc_next  = slip_take ? (acc_cat >> 1) : acc_cat;    // drop oldest bit
	assign fill_next = slip_take ? (fill_cat - 1'b1) : fill_cat;

	assign block_ready = (fill_next >= NB_FILL'(NB_BLOCK));

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			fill          <= '0;
			slip_pend     <= 1'b0;
			block_valid_q <= 1'b0;
		end
		else
		begin
			slip_pend     <= slip_req && !slip_take;
			block_valid_q <= block_ready;
			if (block_ready)
				fill <= fill_next - NB_FILL'(NB_BLOCK);
			else
				fill <= fill_next;
		end
	end

	// bit store and output block
	always_ff @(posedge i_clock)
	begin
		if (block_ready)
		begin
			acc     <= acc_next >> NB_BLOCK;
			block_q <= acc_next[NB_BLOCK-1:0];
		end
		else
		begin
			acc <= acc_next;
		end
	end

	assign o_block       = block_q;
	assign o_block_valid = block_valid_q;

endmodule

`default_nettype wire

// File: verilog/block_lock_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module block_lock_fsm
#(
	parameter int GOOD_TO_LOCK    = 64,
	parameter int WINDOW_HEADERS  = 1024,
	parameter int INVALID_TO_SLIP = 65
)
(
	input  wire                                i_clock,
	input  wire                                i_reset,
	input  wire                                i_signal_ok,
	input  wire [pcs_sync_pkg::NB_HEADER-1:0]  i_header,
	input  wire                                i_header_valid,
	output wire                                o_block_lock,
	output wire                                o_slip
);

	localparam int CNT_MAX = (GOOD_TO_LOCK > WINDOW_HEADERS) ? GOOD_TO_LOCK : WINDOW_HEADERS;
	localparam int NB_CNT  = $clog2(CNT_MAX + 1);
	localparam int NB_INV  = $clog2(INVALID_TO_SLIP + 1);

	pcs_sync_pkg::lock_state_t state;
	pcs_sync_pkg::lock_state_t state_next;

	logic [NB_CNT-1:0] sh_cnt;          // good headers when hunting, window position when locked
	logic [NB_CNT-1:0] sh_cnt_next;
	logic [NB_CNT-1:0] sh_cnt_inc;
	logic [NB_INV-1:0] invld_cnt;
	logic [NB_INV-1:0] invld_cnt_next;
	logic [NB_INV-1:0] invld_cnt_inc;
	logic              block_lock;
	logic              block_lock_next;
	logic              slip;
	logic              slip_next;
	logic              sh_valid;

	assign sh_valid = (i_header == pcs_sync_pkg::SH_DATA) ||
	                  (i_header == pcs_sync_pkg::SH_CTRL);

	assign sh_cnt_inc    = sh_cnt + 1'b1;
	assign invld_cnt_inc = invld_cnt + 1'b1;

	always_comb
	begin
		state_next      = state;
		sh_cnt_next     = sh_cnt;
		invld_cnt_next  = invld_cnt;
		block_lock_next = block_lock;
		slip_next       = 1'b0;

		// housekeeping between headers
		case (state)
			pcs_sync_pkg::LOCK_INIT:
			begin
				block_lock_next = 1'b0;
				sh_cnt_next     = '0;
				invld_cnt_next  = '0;
				state_next      = pcs_sync_pkg::RESET_CNT;
			end
			pcs_sync_pkg::RESET_CNT,
			pcs_sync_pkg::GOOD_64,
			pcs_sync_pkg::SLIP:
			begin
				sh_cnt_next    = '0;
				invld_cnt_next = '0;
				state_next     = pcs_sync_pkg::RESET_CNT;
			end
			default:
			begin
				state_next = state;             // wait for next header
			end
		endcase

		// one decision per header strobe
		if (i_header_valid && (state != pcs_sync_pkg::LOCK_INIT))
		begin
			if (!block_lock)
			begin
				if (!sh_valid)
				begin
					// any bad header while hunting moves the boundary
					sh_cnt_next    = '0;
					invld_cnt_next = '0;
					slip_next      = 1'b1;
					state_next     = pcs_sync_pkg::SLIP;
				end
				else if (sh_cnt_inc == NB_CNT'(GOOD_TO_LOCK))
				begin
					sh_cnt_next     = '0;
					invld_cnt_next  = '0;
					block_lock_next = 1'b1;
					state_next      = pcs_sync_pkg::GOOD_64;
				end
				else
				begin
					sh_cnt_next = sh_cnt_inc;
					state_next  = pcs_sync_pkg::TEST_SH;
				end
			end
			else
			begin
				sh_cnt_next = sh_cnt_inc;
				if (!sh_valid)
					invld_cnt_next = invld_cnt_inc;

				if (!sh_valid && (invld_cnt_inc == NB_INV'(INVALID_TO_SLIP)))
				begin
					sh_cnt_next     = '0;
					invld_cnt_next  = '0;
					block_lock_next = 1'b0;
					slip_next       = 1'b1;
					state_next      = pcs_sync_pkg::SLIP;
				end
				else if (sh_cnt_inc == NB_CNT'(WINDOW_HEADERS))
				begin
					// window survived, start a fresh one
					sh_cnt_next    = '0;
					invld_cnt_next = '0;
					state_next     = pcs_sync_pkg::RESET_CNT;
				end
				else
				begin
					state_next = sh_valid ? pcs_sync_pkg::TEST_SH2 : pcs_sync_pkg::INVALID_SH;
				end
			end
		end

		// signal loss overrides everything
		if (!i_signal_ok)
		begin
			sh_cnt_next     = '0;
			invld_cnt_next  = '0;
			block_lock_next = 1'b0;
			slip_next       = 1'b0;
			state_next      = pcs_sync_pkg::LOCK_INIT;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state      <= pcs_sync_pkg::LOCK_INIT;
			sh_cnt     <= '0;
			invld_cnt  <= '0;
			block_lock <= 1'b0;
			slip       <= 1'b0;
		end
		else
		begin
			state      <= state_next;
			sh_cnt     <= sh_cnt_next;
			invld_cnt  <= invld_cnt_next;
			block_lock <= block_lock_next;
			slip       <= slip_next;
		end
	end

	assign o_block_lock = block_lock;
	assign o_slip       = slip;

endmodule

`default_nettype wire

// File: verilog/descrambler.sv
`timescale 1ns/1ns
`default_nettype none

module descrambler
(
	input  wire                                 i_clock,
	input  wire                                 i_reset,
	input  wire [pcs_sync_pkg::NB_BLOCK-1:0]    i_block,
	input  wire                                 i_block_valid,
	output wire [pcs_sync_pkg::NB_PAYLOAD-1:0]  o_data,
	output wire [pcs_sync_pkg::NB_HEADER-1:0]   o_header,
	output wire                                 o_data_valid
);

	localparam int NB_BLOCK   = pcs_sync_pkg::NB_BLOCK;
	localparam int NB_PAYLOAD = pcs_sync_pkg::NB_PAYLOAD;
	localparam int NB_HEADER  = pcs_sync_pkg::NB_HEADER;
	localparam int TAP_A      = pcs_sync_pkg::SCR_TAP_A;
	localparam int TAP_B      = pcs_sync_pkg::SCR_TAP_B;
	localparam int NB_STATE   = TAP_B;       // longest tap sets the history depth

	logic [NB_STATE-1:0]            scr_state;   // msb is the most recent scrambled bit
	logic [NB_STATE+NB_PAYLOAD-1:0] history;
	logic [NB_PAYLOAD-1:0]          payload;
	logic [NB_PAYLOAD-1:0]          plain;
	logic [NB_PAYLOAD-1:0]          data_q;
	logic [NB_HEADER-1:0]           header_q;
	logic                           data_valid_q;

	assign payload = i_block[NB_BLOCK-1:NB_HEADER];
	assign history = {payload, scr_state};     // oldest bit at index 0

	// each bit xor the bits 39 and 58 positions earlier
	always_comb
	begin
		for (int i = 0; i < NB_PAYLOAD; i++)
		begin
			plain[i] = history[NB_STATE+i] ^ history[NB_STATE+i-TAP_A] ^
			           history[NB_STATE+i-TAP_B];
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_block_valid)
		begin
			scr_state <= history[NB_PAYLOAD +: NB_STATE];  // keep the newest 58 received bits
			data_q    <= plain;
			header_q  <= i_block[NB_HEADER-1:0];
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			data_valid_q <= 1'b0;
		else
			data_valid_q <= i_block_valid;
	end

	assign o_data       = data_q;
	assign o_header     = header_q;
	assign o_data_valid = data_valid_q;

endmodule

`default_nettype wire

// File: verilog/pcs_block_sync.sv
`timescale 1ns/1ns
`default_nettype none

module pcs_block_sync
#(
	parameter int NB_WORD         = 32,
	parameter int GOOD_TO_LOCK    = 64,
	parameter int WINDOW_HEADERS  = 1024,
	parameter int INVALID_TO_SLIP = 65
)
(
	input  wire                                 i_clock,
	input  wire                                 i_reset,
	input  wire [NB_WORD-1:0]                   i_data,
	input  wire                                 i_data_valid,
	input  wire                                 i_signal_ok,
	output wire [pcs_sync_pkg::NB_PAYLOAD-1:0]  o_data,
	output wire [pcs_sync_pkg::NB_HEADER-1:0]   o_header,
	output wire                                 o_data_valid,
	output wire                                 o_block_lock
);

	wire [pcs_sync_pkg::NB_BLOCK-1:0] block;
	wire                              block_valid;
	wire                              slip;

	// cuts the bit stream into 66-bit blocks
	block_aligner
	#(
		.NB_WORD (NB_WORD)
	)
	block_aligner_inst
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_data        (i_data),
		.i_data_valid  (i_data_valid),
		.i_slip        (slip),
		.o_block       (block),
		.o_block_valid (block_valid)
	);

	block_lock_fsm
	#(
		.GOOD_TO_LOCK    (GOOD_TO_LOCK),
		.WINDOW_HEADERS  (WINDOW_HEADERS),
		.INVALID_TO_SLIP (INVALID_TO_SLIP)
	)
	block_lock_fsm_inst
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_signal_ok    (i_signal_ok),
		.i_header       (block[pcs_sync_pkg::NB_HEADER-1:0]),   // header is first on the wire
		.i_header_valid (block_valid),
		.o_block_lock   (o_block_lock),
		.o_slip         (slip)
	);

	// payload descrambled whether locked or not
	descrambler descrambler_inst
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_block       (block),
		.i_block_valid (block_valid),
		.o_data        (o_data),
		.o_header      (o_header),
		.o_data_valid  (o_data_valid)
	);

endmodule

`default_nettype wire

// File: verilog/pcs_sync_pkg.sv
`default_nettype none

package pcs_sync_pkg;

	// block geometry, header sits in bits 1:0
	localparam int NB_BLOCK   = 66;
	localparam int NB_PAYLOAD = 64;
	localparam int NB_HEADER  = 2;

	// valid sync headers, 00 and 11 are errors
	localparam logic [NB_HEADER-1:0] SH_DATA = 2'b01;
	localparam logic [NB_HEADER-1:0] SH_CTRL = 2'b10;

	// descrambler polynomial 1 + x^39 + x^58
	localparam int SCR_TAP_A = 39;
	localparam int SCR_TAP_B = 58;

	// block lock states
	typedef enum logic [2:0]
	{
		LOCK_INIT  = 3'd0,  // after reset or signal loss
		RESET_CNT  = 3'd1,  // counters cleared, waiting for header
		TEST_SH    = 3'd2,  // hunting, last header good
		GOOD_64    = 3'd3,  // lock just set
		TEST_SH2   = 3'd4,  // locked, last header good
		INVALID_SH = 3'd5,  // locked, last header bad
		SLIP       = 3'd6   // lock dropped, slip requested
	} lock_state_t;

endpackage

`default_nettype wire
